// File: sources.f
+incdir+tests
design/priv_pkg.sv
design/csr_pkg.sv
design/priv_exec.sv
design/csr_regfile.sv
design/tlb_array.sv
design/priv_unit.sv
tests/priv_unit_tb.sv

// File: Makefile
TOP := priv_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timescale 1ns/10ps --top-module priv_unit -f sources.f

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "=== PASS ===" sim.log && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tests/priv_ref.svh
`ifndef PRIV_REF_SVH
`define PRIV_REF_SVH

logic [31:0] m_csr  [7];  // crmd prmd era tlbidx tlbehi tlbelo asid
logic [18:0] m_vppn [TLB_ENTRIES];
logic [9:0]  m_asid [TLB_ENTRIES];
logic [19:0] m_ppn  [TLB_ENTRIES];
logic        m_g    [TLB_ENTRIES];
logic        m_v    [TLB_ENTRIES];
int          m_victim;

function automatic void reset_model();
    for (int n = 0; n < 7; n++)
        m_csr[n] = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        m_vppn[i] = '0;
        m_asid[i] = '0;
        m_ppn[i]  = '0;
        m_g[i]    = 1'b0;
        m_v[i]    = 1'b0;
    end
    m_victim = 0;
endfunction

function automatic int csr_slot(input logic [13:0] a);
    case (a)
        CSR_CRMD:   return 0;
        CSR_PRMD:   return 1;
        CSR_ERA:    return 2;
        CSR_TLBIDX: return 3;
        CSR_TLBEHI: return 4;
        CSR_TLBELO: return 5;
        CSR_ASID:   return 6;
        default:    return -1;
    endcase
endfunction

// returns the old value, then applies the masked write
function automatic logic [31:0] apply_csr_write(input logic [13:0] a, input logic [4:0] rj,
                                                input logic [31:0] mask,
                                                input logic [31:0] data);
    int          s;
    logic [31:0] old;
    logic [31:0] we;
    s   = csr_slot(a);
    old = (s < 0) ? 32'h0 : m_csr[s];
    we  = (rj == 5'd0) ? 32'h0 : (rj == 5'd1) ? 32'hffff_ffff : mask;
    if (s >= 0)
        m_csr[s] = (old & ~we) | (data & we);
    return old;
endfunction

function automatic logic [31:0] restore_mode();
    m_csr[0][1:0] = m_csr[1][1:0];  // plv from pplv
    m_csr[0][2]   = m_csr[1][2];
    return m_csr[2];
endfunction

function automatic void model_tlb_op(input logic [2:0] op);
    int   idx;
    logic hit;
    idx = int'(m_csr[3][IW-1:0]);
    case (op)
        TLB_OP_SRCH: begin
            hit = 1'b0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (m_v[i] && m_vppn[i] == m_csr[4][31:13]
                    && (m_g[i] || m_asid[i] == m_csr[6][9:0])) begin
                    hit = 1'b1;
                    m_csr[3][IW-1:0] = IW'(i);
                end
            end
            m_csr[3][31] = !hit;
        end
        TLB_OP_RD: begin
            if (m_v[idx]) begin
                m_csr[4]      = {m_vppn[idx], 13'h0};
                m_csr[5]      = {4'h0, m_ppn[idx], 1'b0, m_g[idx], 5'h0, 1'b1};
                m_csr[6][9:0] = m_asid[idx];
            end else begin
                m_csr[4]      = '0;
                m_csr[5]      = '0;
                m_csr[6][9:0] = '0;
            end
            m_csr[3][31] = !m_v[idx];
        end
        TLB_OP_WR, TLB_OP_FILL: begin
            if (op == TLB_OP_FILL)
                idx = m_victim;
            m_vppn[idx] = m_csr[4][31:13];
            m_asid[idx] = m_csr[6][9:0];
            m_g[idx]    = m_csr[5][6];
            m_ppn[idx]  = m_csr[5][27:8];
            m_v[idx]    = m_csr[5][0];
            if (op == TLB_OP_FILL)
                m_victim = (m_victim + 1) % TLB_ENTRIES;
        end
        default: ;
    endcase
endfunction

function automatic void invalidate_entries(input logic [4:0] op, input logic [9:0] a,
                                           input logic [31:0] va);
    logic sel;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        case (op)
            5'd0, 5'd1: sel = 1'b1;
            5'd2:       sel = m_g[i];
            5'd3:       sel = !m_g[i];
            5'd4:       sel = !m_g[i] && m_asid[i] == a;
            5'd5:       sel = !m_g[i] && m_asid[i] == a && m_vppn[i] == va[31:13];
            5'd6:       sel = (m_g[i] || m_asid[i] == a) && m_vppn[i] == va[31:13];
            default:    sel = 1'b0;
        endcase
        if (sel)
            m_v[i] = 1'b0;
    end
endfunction

`endif

// File: tests/priv_unit_tb.sv
`timescale 1ns/10ps

module priv_unit_tb
    import priv_pkg::*, csr_pkg::*;
();

    localparam int TLB_ENTRIES = 8;
    localparam int IW = $clog2(TLB_ENTRIES);
    localparam int N_INST = 28 + 16 + (12 * TLB_ENTRIES + 4) + 9 * (TLB_ENTRIES + 2)
                            + 8 * (9 * TLB_ENTRIES + 1);
    localparam logic [13:0] CSR_LIST [7] = '{CSR_CRMD, CSR_PRMD, CSR_ERA, CSR_TLBIDX,
                                             CSR_TLBEHI, CSR_TLBELO, CSR_ASID};
    localparam logic [9:0] ASID_A = 10'h0a5;
    localparam logic [9:0] ASID_B = 10'h15a;

    logic        clk;
    logic        rstn;
    logic        en_in;
    logic        is_csr;
    logic        is_tlb;
    logic        is_ertn;
    inst_word_u  inst;
    logic [31:0] pc_next;
    logic [31:0] sr0;
    logic [31:0] sr1;
    logic [4:0]  addr_in;
    logic        en_out;
    logic        flush;
    logic [31:0] pc_target;
    logic [31:0] result;
    logic [4:0]  addr_out;
    logic        stall;
    int          seed;

    // expected response per outstanding instruction
    logic [31:0] exp_pc [$];
    logic        exp_en [$];
    logic [31:0] exp_res [$];
    logic [4:0]  exp_addr [$];

    `include "priv_ref.svh"

    priv_unit #(.TLB_ENTRIES(TLB_ENTRIES)) dut0 (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    always @(posedge clk) begin
        if (rstn && flush) begin
            if (exp_pc.size() == 0) begin
                $display("flush pulse seen with no instruction outstanding");
                $display("=== FAIL ===");
                $fatal(1, "unexpected flush");
            end else begin
                check_val("pc_target", pc_target, exp_pc.pop_front());
                check_val("en_out", {31'h0, en_out}, {31'h0, exp_en.pop_front()});
                check_val("result", result, exp_res.pop_front());
                check_val("addr_out", {27'h0, addr_out}, {27'h0, exp_addr.pop_front()});
            end
        end
    end

    task automatic issue(input inst_word_u iw, input logic [2:0] kind, input logic [31:0] s0,
                         input logic [31:0] s1, input logic [31:0] pc, input logic [4:0] ad,
                         input logic [31:0] e_pc, input logic e_en, input logic [31:0] e_res,
                         input logic [4:0] e_addr);
        @(posedge clk);
        #2;
        while (stall) begin
            @(posedge clk);
            #2;
        end
        exp_pc.push_back(e_pc);
        exp_en.push_back(e_en);
        exp_res.push_back(e_res);
        exp_addr.push_back(e_addr);
        {is_csr, is_tlb, is_ertn} = kind;
        inst    = iw;
        sr0     = s0;
        sr1     = s1;
        pc_next = pc;
        addr_in = ad;
        en_in   = 1'b1;
        @(posedge clk);
        #2;
        en_in = 1'b0;
        check_val("stall while running", {31'h0, stall}, 32'h1);
        while (!flush) begin
            @(posedge clk);
            #2;
        end
        check_val("stall at flush", {31'h0, stall}, 32'h0);
        @(posedge clk);  // compare runs here
    endtask

    task automatic csr_access(input logic [13:0] a, input logic [4:0] rj,
                              input logic [31:0] mask, input logic [31:0] data);
        inst_word_u  iw;
        logic [31:0] pc;
        logic [31:0] old;
        iw = '0;
        iw.csr_view.csr = a;
        iw.csr_view.rj  = rj;
        iw.csr_view.rd  = 5'($random(seed));
        pc  = $random(seed);
        old = apply_csr_write(a, rj, mask, data);
        issue(iw, 3'b100, mask, data, pc, iw.csr_view.rd, pc, 1'b1, old, iw.csr_view.rd);
    endtask

    task automatic exception_return();
        inst_word_u  iw;
        logic [31:0] pc;
        logic [31:0] tgt;
        iw  = 32'h0648_3800;
        pc  = $random(seed);
        tgt = restore_mode();
        issue(iw, 3'b001, 32'h0, 32'h0, pc, 5'($random(seed)), tgt, 1'b1, 32'h0, 5'h0);
    endtask

    task automatic tlb_command(input logic [1:0] cls, input logic [2:0] op,
                               input logic [4:0] iop, input logic [31:0] s0,
                               input logic [31:0] s1);
        inst_word_u  iw;
        logic [31:0] pc;
        iw = '0;
        iw.tlb_view.cls    = cls;
        iw.tlb_view.op     = op;
        iw.tlb_view.inv_op = iop;
        pc = $random(seed);
        if (cls == TLB_CLASS_INV)
            invalidate_entries(iop, s0[9:0], s1);
        else
            model_tlb_op(op);
        issue(iw, 3'b010, s0, s1, pc, 5'($random(seed)), pc, 1'b0, 32'h0, 5'h0);
    endtask

    // vppn is {tag, random, k} so entries of one phase never alias
    task automatic write_entry(input logic [2:0] op, input int idx, input logic [2:0] tag,
                               input int k, input logic g, input logic [9:0] a);
        logic [31:0] elo;
        elo    = $random(seed);
        elo[0] = 1'b1;
        elo[6] = g;
        csr_access(CSR_TLBIDX, 5'd1, 32'h0, 32'(idx));
        csr_access(CSR_TLBEHI, 5'd1, 32'h0,
                   {tag, 11'($random(seed)), 5'(k), 13'($random(seed))});
        csr_access(CSR_ASID, 5'd1, 32'h0, {22'h0, a});
        csr_access(CSR_TLBELO, 5'd1, 32'h0, elo);
        tlb_command(TLB_CLASS_OP, op, 5'd0, 32'h0, 32'h0);
    endtask

    task automatic search(input logic [18:0] vppn, input logic [9:0] a);
        csr_access(CSR_TLBEHI, 5'd1, 32'h0, {vppn, 13'($random(seed))});
        csr_access(CSR_ASID, 5'd1, 32'h0, {22'($random(seed)), a});
        tlb_command(TLB_CLASS_OP, TLB_OP_SRCH, 5'd0, 32'h0, 32'h0);
        csr_access(CSR_TLBIDX, 5'd0, 32'h0, 32'h0);  // index or ne
    endtask

    task automatic fill_and_search();
        logic [18:0] vp [TLB_ENTRIES+2];
        logic [9:0]  as [TLB_ENTRIES+2];
        for (int k = 0; k < TLB_ENTRIES + 2; k++) begin
            write_entry(TLB_OP_FILL, 0, 3'd2, k, 1'b0, 10'($random(seed)));
            vp[k] = m_csr[4][31:13];
            as[k] = m_csr[6][9:0];
        end
        for (int k = 0; k < TLB_ENTRIES + 2; k++)
            search(vp[k], as[k]);  // first two were overwritten
    endtask

    initial begin
        seed    = 32'h32fb7731;
        rstn    = 1'b0;
        en_in   = 1'b0;
        is_csr  = 1'b0;
        is_tlb  = 1'b0;
        is_ertn = 1'b0;
        inst    = '0;
        pc_next = '0;
        sr0     = '0;
        sr1     = '0;
        addr_in = '0;
        reset_model();
        repeat (16) @(posedge clk);
        #2 rstn = 1'b1;
        for (int n = 0; n < 7; n++) begin
            csr_access(CSR_LIST[n], 5'd1, $random(seed), $random(seed));
            csr_access(CSR_LIST[n], 5'd0, $random(seed), $random(seed));
        end
        for (int n = 0; n < 7; n++) begin
            csr_access(CSR_LIST[n], 5'd2 + 5'(n), $random(seed), $random(seed));
            csr_access(CSR_LIST[n], 5'd0, 32'h0, 32'h0);
        end
        repeat (4) begin
            csr_access(CSR_ERA, 5'd1, 32'h0, $random(seed));
            csr_access(CSR_PRMD, 5'd1, 32'h0, $random(seed));
            exception_return();
            csr_access(CSR_CRMD, 5'd0, 32'h0, 32'h0);
        end
        for (int i = 0; i < TLB_ENTRIES; i++)
            write_entry(TLB_OP_WR, i, 3'd1, i, 1'($random(seed)), 10'($random(seed)));
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            search(m_vppn[i], m_asid[i]);
            tlb_command(TLB_CLASS_OP, TLB_OP_RD, 5'd0, 32'h0, 32'h0);
            csr_access(CSR_TLBEHI, 5'd0, 32'h0, 32'h0);
            csr_access(CSR_TLBELO, 5'd0, 32'h0, 32'h0);
        end
        search({3'd7, 16'($random(seed))}, 10'h0);  // tag 7 is never written
        fill_and_search();
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < TLB_ENTRIES; i++)
                write_entry(TLB_OP_WR, i, 3'd3, i, i % 3 == 0, i[0] ? ASID_A : ASID_B);
            tlb_command(TLB_CLASS_INV, 3'd0, 5'(op), {22'($random(seed)), ASID_A},
                        {m_vppn[op % TLB_ENTRIES], 13'($random(seed))});
            for (int i = 0; i < TLB_ENTRIES; i++)
                search(m_vppn[i], m_asid[i]);
        end
        repeat (4) @(posedge clk);
        if (exp_pc.size() != 0) begin
            $display("%0d instructions never completed", exp_pc.size());
            $display("=== FAIL ===");
            $fatal(1, "instructions outstanding at end of run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    initial begin
        #((N_INST * 10 + 16) * 20);
        $display("timeout, run took longer than %0d cycles", N_INST * 10 + 16);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: design/priv_unit.sv
`timescale 1ns/10ps

module priv_unit
    import priv_pkg::*, csr_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        en_in,
    input  logic        is_csr,
    input  logic        is_tlb,
    input  logic        is_ertn,
    input  inst_word_u  inst,
    input  logic [31:0] pc_next,
    input  logic [31:0] sr0,
    input  logic [31:0] sr1,
    input  logic [4:0]  addr_in,
    output logic        en_out,
    output logic        flush,
    output logic [31:0] pc_target,
    output logic [31:0] result,
    output logic [4:0]  addr_out,
    output logic        stall
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // executor to csr file
    logic              csr_query;
    logic [13:0]       csr_addr;
    logic [31:0]       csr_wen;
    logic [31:0]       csr_wdata;
    logic [31:0]       csr_rdata;
    logic [31:0]       era;
    logic              restore_state;
    // executor to tlb
    logic              srch_en;
    logic              rd_en;
    logic              wr_en;
    logic              fill_en;
    logic              inv_en;
    inv_op_t           inv_op;
    logic [ASID_W-1:0] inv_asid;
    logic [31:0]       inv_vaddr;
    // csr file and tlb
    logic [31:0]       tlbidx;
    logic [31:0]       tlbehi;
    logic [31:0]       tlbelo;
    logic [31:0]       asid;
    logic              srch_we;
    logic              srch_hit;
    logic [IDX_W-1:0]  srch_index;
    logic              rd_we;
    logic              rd_valid;
    logic [31:0]       rd_ehi;
    logic [31:0]       rd_elo;
    logic [ASID_W-1:0] rd_asid;

    priv_exec exec0 (.*);

    csr_regfile #(.TLB_ENTRIES(TLB_ENTRIES)) csr0 (.*);

    tlb_array #(.TLB_ENTRIES(TLB_ENTRIES)) tlb0 (.*);

endmodule

// File: design/tlb_array.sv
`timescale 1ns/10ps

module tlb_array
    import priv_pkg::*, csr_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   srch_en,
    input  logic                   rd_en,
    input  logic                   wr_en,
    input  logic                   fill_en,
    input  logic                   inv_en,
    input  inv_op_t                inv_op,
    input  logic [ASID_W-1:0]      inv_asid,
    input  logic [31:0]            inv_vaddr,
    input  logic [31:0]            tlbidx,
    input  logic [31:0]            tlbehi,
    input  logic [31:0]            tlbelo,
    input  logic [31:0]            asid,
    output logic                   srch_we,
    output logic                   srch_hit,
    output logic [$clog2(TLB_ENTRIES)-1:0] srch_index,
    output logic                   rd_we,
    output logic                   rd_valid,
    output logic [31:0]            rd_ehi,
    output logic [31:0]            rd_elo,
    output logic [ASID_W-1:0]      rd_asid
);

    localparam int IDX_W  = $clog2(TLB_ENTRIES);
    localparam int VPPN_W = EHI_VPPN_HI - EHI_VPPN_LO + 1;
    localparam int PPN_W  = ELO_PPN_HI - ELO_PPN_LO + 1;

    logic [VPPN_W-1:0]      vppn   [TLB_ENTRIES];
    logic [ASID_W-1:0]      e_asid [TLB_ENTRIES];
    logic [PPN_W-1:0]       ppn    [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] g;
    logic [TLB_ENTRIES-1:0] v;

    logic [TLB_ENTRIES-1:0] hit_vec;
    logic [TLB_ENTRIES-1:0] inv_va;
    logic [TLB_ENTRIES-1:0] inv_as;
    logic [TLB_ENTRIES-1:0] kill;
    logic [IDX_W-1:0]       hit_idx;
    logic [IDX_W-1:0]       rd_idx;
    logic [IDX_W-1:0]       wr_idx;
    logic [IDX_W-1:0]       victim;  // round-robin fill pointer

    assign rd_idx = tlbidx[IDX_W-1:0];
    assign wr_idx = fill_en ? victim : rd_idx;

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = v[i] && vppn[i] == tlbehi[EHI_VPPN_HI:EHI_VPPN_LO]
                         && (g[i] || e_asid[i] == asid[ASID_HI:0]);
            inv_va[i]  = vppn[i] == inv_vaddr[EHI_VPPN_HI:EHI_VPPN_LO];
            inv_as[i]  = e_asid[i] == inv_asid;
        end
    end

    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--)
            if (hit_vec[i])
                hit_idx = IDX_W'(i);
    end

    always_comb begin
        case (inv_op)
            INV_ALL0, INV_ALL: kill = '1;
            INV_GLOBAL:        kill = g;
            INV_NONGLOBAL:     kill = ~g;
            INV_ASID:          kill = ~g & inv_as;
            INV_ASID_VA:       kill = ~g & inv_as & inv_va;
            INV_GA_VA:         kill = (g | inv_as) & inv_va;
            default:           kill = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            v       <= '0;
            victim  <= '0;
            srch_we <= 1'b0;
            rd_we   <= 1'b0;
        end else begin
            srch_we <= srch_en;
            rd_we   <= rd_en;
            if (wr_en || fill_en)
                v[wr_idx] <= tlbelo[ELO_V];
            else if (inv_en)
                v <= v & ~kill;
            if (fill_en)
                victim <= victim + 1'b1;
        end
    end

    // entry payload and response data
    always_ff @(posedge clk) begin
        if (wr_en || fill_en) begin
            vppn[wr_idx]   <= tlbehi[EHI_VPPN_HI:EHI_VPPN_LO];
            e_asid[wr_idx] <= asid[ASID_HI:0];
            g[wr_idx]      <= tlbelo[ELO_G];
            ppn[wr_idx]    <= tlbelo[ELO_PPN_HI:ELO_PPN_LO];
        end
        srch_hit   <= |hit_vec;
        srch_index <= hit_idx;
        rd_valid   <= v[rd_idx];
        rd_asid    <= e_asid[rd_idx];
        rd_ehi     <= '0;
        rd_ehi[EHI_VPPN_HI:EHI_VPPN_LO] <= vppn[rd_idx];
        rd_elo     <= '0;
        rd_elo[ELO_V] <= v[rd_idx];
        rd_elo[ELO_G] <= g[rd_idx];
        rd_elo[ELO_PPN_HI:ELO_PPN_LO] <= ppn[rd_idx];
    end

    a_single_hit: assert property (@(posedge clk) disable iff (!rstn)
        srch_en |-> $onehot0(hit_vec));

endmodule

// File: design/csr_regfile.sv
`timescale 1ns/10ps

module csr_regfile
    import csr_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   csr_query,
    input  logic [13:0]            csr_addr,
    input  logic [31:0]            csr_wen,
    input  logic [31:0]            csr_wdata,
    input  logic                   restore_state,
    input  logic                   srch_we,
    input  logic                   srch_hit,
    input  logic [$clog2(TLB_ENTRIES)-1:0] srch_index,
    input  logic                   rd_we,
    input  logic                   rd_valid,
    input  logic [31:0]            rd_ehi,
    input  logic [31:0]            rd_elo,
    input  logic [ASID_W-1:0]      rd_asid,
    output logic [31:0]            csr_rdata,
    output logic [31:0]            era,
    output logic [31:0]            tlbidx,
    output logic [31:0]            tlbehi,
    output logic [31:0]            tlbelo,
    output logic [31:0]            asid
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] wr_val;

    always_comb begin
        case (csr_addr)
            CSR_CRMD:   csr_rdata = crmd;
            CSR_PRMD:   csr_rdata = prmd;
            CSR_ERA:    csr_rdata = era;
            CSR_TLBIDX: csr_rdata = tlbidx;
            CSR_TLBEHI: csr_rdata = tlbehi;
            CSR_TLBELO: csr_rdata = tlbelo;
            CSR_ASID:   csr_rdata = asid;
            default:    csr_rdata = '0;
        endcase
    end

    assign wr_val = (csr_rdata & ~csr_wen) | (csr_wdata & csr_wen);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd   <= '0;
            prmd   <= '0;
            era    <= '0;
            tlbidx <= '0;
            tlbehi <= '0;
            tlbelo <= '0;
            asid   <= '0;
        end else begin
            if (csr_query) begin
                case (csr_addr)
                    CSR_CRMD:   crmd   <= wr_val;
                    CSR_PRMD:   prmd   <= wr_val;
                    CSR_ERA:    era    <= wr_val;
                    CSR_TLBIDX: tlbidx <= wr_val;
                    CSR_TLBEHI: tlbehi <= wr_val;
                    CSR_TLBELO: tlbelo <= wr_val;
                    CSR_ASID:   asid   <= wr_val;
                    default: ;
                endcase
            end
            if (restore_state) begin  // ertn
                crmd[CRMD_PLV_HI:CRMD_PLV_LO] <= prmd[PRMD_PPLV_HI:PRMD_PPLV_LO];
                crmd[CRMD_IE]                 <= prmd[PRMD_PIE];
            end
            if (srch_we) begin
                if (srch_hit)
                    tlbidx[IDX_W-1:0] <= srch_index;
                tlbidx[TLBIDX_NE] <= !srch_hit;
            end
            if (rd_we) begin
                tlbehi            <= rd_valid ? rd_ehi : '0;
                tlbelo            <= rd_valid ? rd_elo : '0;
                asid[ASID_HI:0]   <= rd_valid ? rd_asid : '0;
                tlbidx[TLBIDX_NE] <= !rd_valid;
            end
        end
    end

    a_no_restore_query: assert property (@(posedge clk) disable iff (!rstn)
        !(restore_state && csr_query));

endmodule

// File: design/priv_exec.sv
`timescale 1ns/10ps

module priv_exec
    import priv_pkg::*, csr_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              en_in,
    input  logic              is_csr,
    input  logic              is_tlb,
    input  logic              is_ertn,
    input  inst_word_u        inst,
    input  logic [31:0]       pc_next,
    input  logic [31:0]       sr0,        // rj value
    input  logic [31:0]       sr1,        // rk value
    input  logic [4:0]        addr_in,
    input  logic [31:0]       csr_rdata,  // read first
    input  logic [31:0]       era,
    output logic              en_out,
    output logic              flush,
    output logic              stall,
    output logic [31:0]       pc_target,
    output logic [31:0]       result,
    output logic [4:0]        addr_out,
    output logic              csr_query,
    output logic [13:0]       csr_addr,
    output logic [31:0]       csr_wen,    // per-bit write enable
    output logic [31:0]       csr_wdata,
    output logic              restore_state,
    output logic              srch_en,
    output logic              rd_en,
    output logic              wr_en,
    output logic              fill_en,
    output logic              inv_en,
    output inv_op_t           inv_op,
    output logic [ASID_W-1:0] inv_asid,
    output logic [31:0]       inv_vaddr
);

    localparam logic [6:0] S_INIT      = 7'b0000001;
    localparam logic [6:0] S_CSR       = 7'b0000010;
    localparam logic [6:0] S_TLB       = 7'b0000100;
    localparam logic [6:0] S_ERTN      = 7'b0001000;
    localparam logic [6:0] S_DONE_CSR  = 7'b0010000;
    localparam logic [6:0] S_DONE_TLB  = 7'b0100000;
    localparam logic [6:0] S_DONE_ERTN = 7'b1000000;

    logic [6:0]  state;
    logic [6:0]  next_state;
    logic [31:0] wen_mask;
    inv_op_t     inv_op_n;
    logic        tlb_op_go;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_INIT;
        end else begin
            state <= next_state;
        end
    end

    // done states already have stall low, so they take a new instruction too
    always_comb begin
        case (state)
            S_CSR:   next_state = S_DONE_CSR;
            S_TLB:   next_state = S_DONE_TLB;
            S_ERTN:  next_state = S_DONE_ERTN;
            default: begin
                if (en_in && is_csr)
                    next_state = S_CSR;
                else if (en_in && is_tlb)
                    next_state = S_TLB;
                else if (en_in && is_ertn)
                    next_state = S_ERTN;
                else
                    next_state = S_INIT;
            end
        endcase
    end

    always_comb begin
        case (inst.csr_view.rj)
            5'd0:    wen_mask = '0;   // csrrd
            5'd1:    wen_mask = '1;   // csrwr
            default: wen_mask = sr0;  // csrxchg
        endcase
    end

    always_comb begin
        if (inst.tlb_view.inv_op == 5'd0)
            inv_op_n = INV_ALL;
        else if (inst.tlb_view.inv_op >= 5'd7)
            inv_op_n = INV_NOP;
        else
            inv_op_n = inv_op_t'(inst.tlb_view.inv_op[2:0]);
    end

    assign tlb_op_go = next_state == S_TLB && inst.tlb_view.cls == TLB_CLASS_OP;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en_out        <= 1'b0;
            flush         <= 1'b0;
            stall         <= 1'b0;
            csr_query     <= 1'b0;
            restore_state <= 1'b0;
            srch_en       <= 1'b0;
            rd_en         <= 1'b0;
            wr_en         <= 1'b0;
            fill_en       <= 1'b0;
            inv_en        <= 1'b0;
        end else begin
            en_out        <= next_state == S_DONE_CSR || next_state == S_DONE_ERTN;
            flush         <= next_state inside {S_DONE_CSR, S_DONE_TLB, S_DONE_ERTN};
            stall         <= next_state inside {S_CSR, S_TLB, S_ERTN};
            csr_query     <= next_state == S_CSR;
            restore_state <= next_state == S_ERTN;
            srch_en       <= tlb_op_go && inst.tlb_view.op == TLB_OP_SRCH;
            rd_en         <= tlb_op_go && inst.tlb_view.op == TLB_OP_RD;
            wr_en         <= tlb_op_go && inst.tlb_view.op == TLB_OP_WR;
            fill_en       <= tlb_op_go && inst.tlb_view.op == TLB_OP_FILL;
            inv_en        <= next_state == S_TLB && inst.tlb_view.cls == TLB_CLASS_INV;
        end
    end

    always_ff @(posedge clk) begin
        case (next_state)
            S_CSR: begin
                pc_target <= pc_next;
                addr_out  <= addr_in;
                csr_addr  <= inst.csr_view.csr;
                csr_wen   <= wen_mask;
                csr_wdata <= sr1;
            end
            S_TLB: begin
                pc_target <= pc_next;
                addr_out  <= '0;
                inv_op    <= inv_op_n;
                inv_asid  <= sr0[ASID_W-1:0];
                inv_vaddr <= sr1;
            end
            S_ERTN: begin
                pc_target <= era;
                addr_out  <= '0;
            end
            S_DONE_CSR:              result <= csr_rdata;  // old value
            S_DONE_TLB, S_DONE_ERTN: result <= '0;
            default: ;
        endcase
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot(state));

    // every strobe to the csr file or tlb belongs to a running sequence
    a_strobe_stall: assert property (@(posedge clk) disable iff (!rstn)
        (csr_query || restore_state || srch_en || rd_en || wr_en || fill_en || inv_en)
        |-> stall);

endmodule

// File: design/csr_pkg.sv
package csr_pkg;

    localparam logic [13:0] CSR_CRMD   = 14'h00;
    localparam logic [13:0] CSR_PRMD   = 14'h01;
    localparam logic [13:0] CSR_ERA    = 14'h06;
    localparam logic [13:0] CSR_TLBIDX = 14'h10;
    localparam logic [13:0] CSR_TLBEHI = 14'h11;
    localparam logic [13:0] CSR_TLBELO = 14'h12;
    localparam logic [13:0] CSR_ASID   = 14'h18;

    // crmd / prmd
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PIE     = 2;

    localparam int TLBIDX_NE = 31;  // index sits in the low bits

    localparam int EHI_VPPN_LO = 13;
    localparam int EHI_VPPN_HI = 31;

    localparam int ELO_V      = 0;
    localparam int ELO_G      = 6;
    localparam int ELO_PPN_LO = 8;
    localparam int ELO_PPN_HI = 27;

    localparam int ASID_HI = 9;
    localparam int ASID_W  = ASID_HI + 1;

endpackage

// File: design/priv_pkg.sv
package priv_pkg;

    typedef struct packed {
        logic [7:0]  rsv;
        logic [13:0] csr;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } csr_view_t;

    typedef struct packed {
        logic [14:0] rsv_hi;
        logic [1:0]  cls;
        logic [1:0]  rsv_mid;
        logic [2:0]  op;
        logic [4:0]  rsv_lo;
        logic [4:0]  inv_op;
    } tlb_view_t;

    typedef union packed {
        csr_view_t csr_view;
        tlb_view_t tlb_view;
    } inst_word_u;

    localparam logic [2:0] TLB_OP_SRCH = 3'd2;
    localparam logic [2:0] TLB_OP_RD   = 3'd3;
    localparam logic [2:0] TLB_OP_WR   = 3'd4;
    localparam logic [2:0] TLB_OP_FILL = 3'd5;

    localparam logic [1:0] TLB_CLASS_OP  = 2'd0;
    localparam logic [1:0] TLB_CLASS_INV = 2'd3;

    typedef enum logic [2:0] {
        INV_ALL0      = 3'd0,
        INV_ALL       = 3'd1,
        INV_GLOBAL    = 3'd2,
        INV_NONGLOBAL = 3'd3,
        INV_ASID      = 3'd4,
        INV_ASID_VA   = 3'd5,
        INV_GA_VA     = 3'd6,
        INV_NOP       = 3'd7
    } inv_op_t;

endpackage
